//--- source/acq_pkg.sv
// ****************************
// shared acquisition constants, one conversion cycle is CYCLE_LEN clocks
// STORE_POINT has to stay below CYCLE_LEN or no sample is ever stored
// ****************************
`default_nettype none

package acq_pkg;

   // ****************************
   // sample and cycle geometry
   // ****************************
   localparam int ADC_DATA_WIDTH = 18;                  // bits per sample
   localparam int CYCLE_LEN      = 64;                  // clocks per conversion
   localparam int CNT_WIDTH      = $clog2(CYCLE_LEN);   // 6 bits

   // timing points inside one cycle, all in counts
   localparam int CNVST_LEN   = 8;    // convert strobe high time
   localparam int SHIFT_START = 20;   // first sck pulse

   // one sck pulse every other clock, store right after the last bit
   localparam int STORE_POINT = SHIFT_START + 2 * ADC_DATA_WIDTH;

   // ****************************
   // chopper
   // ****************************
   localparam int CHOP_WIDTH = 16;    // period / duty values, in cycles

   // ****************************
   // acquisition FSM
   // ****************************
   typedef enum logic [1:0] {
      WAIT_TRIG,  // idle until sw trigger edge
      ARMED,      // triggered, waits for cycle boundary
      RUN         // one sample word per conversion
   } acq_state_t;

endpackage : acq_pkg

`default_nettype wire

//--- source/conv_ctrl_if.sv
// ****************************
// conversion timing strobes, all levels on adc_read_clk, no handshake
// ****************************
`default_nettype none

interface conv_ctrl_if;

   logic cycle_start;  // one clock at count 0
   logic cnvst;        // convert strobe level
   logic sck;          // serial clock level
   logic sample_bit;   // lanes sampled at end of this clock
   logic store;        // shift regs -> output, only in RUN
   logic chop_lvl;     // chopper level, from chop_gen

   // sequencer drives all the timing
   modport seq (
      output cycle_start,
      output cnvst,
      output sck,
      output sample_bit,
      output store
   );

   modport chop (input cycle_start, output chop_lvl);

   // deserializer side
   modport data (input sample_bit, input store, input chop_lvl);

endinterface : conv_ctrl_if

`default_nettype wire

//--- source/cycle_timer.sv
// ****************************
// free running, no enable, starts at 0 when reset is released
// ****************************
`default_nettype none

module cycle_timer (
   input  wire logic                          adc_read_clk,
   input  wire logic                          acqe_arst_sync,  // async, active low
   output      logic [acq_pkg::CNT_WIDTH-1:0] count_o          // position in cycle
);

   import acq_pkg::*;

   // last count before wrap
   localparam logic [CNT_WIDTH-1:0] LAST_CNT = CNT_WIDTH'(CYCLE_LEN - 1);

   // ****************************
   // conversion cycle counter
   // ****************************
   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         count_o <= '0;
      end else if (count_o == LAST_CNT) begin
         count_o <= '0;                   // wrap, next cycle
      end else begin
         count_o <= count_o + 1'b1;
      end
   end

endmodule : cycle_timer

`default_nettype wire

//--- source/conv_seq_fsm.sv
// ****************************
// cnvst/sck are registered from the next count, so the first cycle after
// reset has a convert strobe one clock short; strg_i must be synchronous
// ****************************
`default_nettype none

module conv_seq_fsm (
   input  wire logic                          adc_read_clk,
   input  wire logic                          acqe_arst_sync,
   input  wire logic [acq_pkg::CNT_WIDTH-1:0] count_i,   // from cycle_timer
   input  wire logic                          strg_i,    // sw trigger level
   output      logic                          acq_on_o,  // sticky until reset
   conv_ctrl_if.seq                           ctrl
);

   import acq_pkg::*;

   localparam logic [CNT_WIDTH-1:0] LAST_CNT  = CNT_WIDTH'(CYCLE_LEN - 1);
   localparam logic [CNT_WIDTH-1:0] CNVST_CNT = CNT_WIDTH'(CNVST_LEN);
   localparam logic [CNT_WIDTH-1:0] SHIFT_CNT = CNT_WIDTH'(SHIFT_START);
   localparam logic [CNT_WIDTH-1:0] STORE_CNT = CNT_WIDTH'(STORE_POINT);

   logic [1:0]           strg_dly_q;   // [0] newest sample
   logic                 trig_edge;
   acq_state_t           state_q;
   acq_state_t           state_d;
   logic                 cycle_start;
   logic [CNT_WIDTH-1:0] count_nxt;
   logic [CNT_WIDTH-1:0] shift_ofs;    // next count relative to burst start
   logic                 cnvst_q;
   logic                 sck_q;

   // ****************************
   // trigger edge detect
   // ****************************
   // pipe resets to ones, a level held through reset is no edge
   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         strg_dly_q <= 2'b11;
      end else begin
         strg_dly_q <= {strg_dly_q[0], strg_i};
      end
   end

   assign trig_edge = (strg_dly_q == 2'b01);   // old low, new high

   // ****************************
   // acquisition state
   // ****************************
   always_comb begin
      state_d = state_q;
      case (state_q)
         WAIT_TRIG: if (trig_edge) state_d = ARMED;
         ARMED:     if (cycle_start) state_d = RUN;  // align to cycle boundary
         RUN:       state_d = RUN;                   // only reset leaves RUN
         default:   state_d = WAIT_TRIG;
      endcase
   end

   // timing regs are looked ahead one count, so they line up with count_i
   assign count_nxt = (count_i == LAST_CNT) ? '0 : count_i + 1'b1;
   assign shift_ofs = count_nxt - SHIFT_CNT;

   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         state_q <= WAIT_TRIG;
         cnvst_q <= 1'b0;
         sck_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         cnvst_q <= (count_nxt < CNVST_CNT);
         // even offsets in the burst window give ADC_DATA_WIDTH pulses
         sck_q   <= (count_nxt >= SHIFT_CNT) && (count_nxt < STORE_CNT) && !shift_ofs[0];
      end
   end

   assign cycle_start     = (count_i == '0);
   assign acq_on_o        = (state_q != WAIT_TRIG);  // set with the ARMED step

   assign ctrl.cycle_start = cycle_start;
   assign ctrl.cnvst       = cnvst_q;
   assign ctrl.sck         = sck_q;
   assign ctrl.sample_bit  = sck_q;                   // sample at end of sck high
   assign ctrl.store       = (count_i == STORE_CNT) && (state_q == RUN);

endmodule : conv_seq_fsm

`default_nettype wire

//--- source/chop_gen.sv
// ****************************
// counts conversion cycles, max_count_i of 0 or 1 keeps the counter at 0
// ****************************
`default_nettype none

module chop_gen (
   input  wire logic                           adc_read_clk,
   input  wire logic                           acqe_arst_sync,
   input  wire logic                           chop_en_i,
   input  wire logic [acq_pkg::CHOP_WIDTH-1:0] max_count_i,     // period, in cycles
   input  wire logic [acq_pkg::CHOP_WIDTH-1:0] change_count_i,  // high time, in cycles
   conv_ctrl_if.chop                           ctrl
);

   import acq_pkg::*;

   logic [CHOP_WIDTH-1:0] period_q;
   logic [CHOP_WIDTH:0]   period_inc;   // extra bit, no overflow at all ones
   logic [CHOP_WIDTH-1:0] period_nxt;
   logic                  chop_q;

   // ****************************
   // period counter
   // ****************************
   assign period_inc = {1'b0, period_q} + 1'b1;
   // wrap after max_count_i - 1
   assign period_nxt = (period_inc >= {1'b0, max_count_i}) ? '0
                                                           : period_inc[CHOP_WIDTH-1:0];

   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         period_q <= '0;
         chop_q   <= 1'b0;
      end else if (!chop_en_i) begin
         period_q <= '0;                              // held while disabled
         chop_q   <= 1'b0;
      end else if (ctrl.cycle_start) begin
         period_q <= period_nxt;
         // level follows the new count for the whole cycle
         chop_q   <= (period_nxt < change_count_i);
      end
   end

   assign ctrl.chop_lvl = chop_q;

endmodule : chop_gen

`default_nettype wire

//--- source/sdo_shifter.sv
// ****************************
// one lane per channel, MSB first; ADC_CHANNELS even (two lanes per ADC)
// ****************************
`default_nettype none

module sdo_shifter #(
   parameter int ADC_CHANNELS = 4                 // serial data lanes
) (
   input  wire logic                                         adc_read_clk,
   input  wire logic                                         acqe_arst_sync,
   input  wire logic [ADC_CHANNELS-1:0]                      sdo_i,  // lane per channel
   conv_ctrl_if.data                                         ctrl,
   output      logic [ADC_CHANNELS*acq_pkg::ADC_DATA_WIDTH-1:0] sample_data_o,
   output      logic                                         sample_chop_o,
   output      logic                                         sample_valid_o
);

   import acq_pkg::*;

   logic [ADC_DATA_WIDTH-1:0] shift_q [ADC_CHANNELS];   // per lane deserializer

   // ****************************
   // capture and output word
   // ****************************
   always_ff @(posedge adc_read_clk) begin
      for (int ch = 0; ch < ADC_CHANNELS; ch++) begin
         if (ctrl.sample_bit) begin
            shift_q[ch] <= {shift_q[ch][ADC_DATA_WIDTH-2:0], sdo_i[ch]};  // shift in lsb
         end
         // channel 0 in the low bits
         if (ctrl.store) begin
            sample_data_o[ch*ADC_DATA_WIDTH +: ADC_DATA_WIDTH] <= shift_q[ch];
         end
      end
      if (ctrl.store) begin
         sample_chop_o <= ctrl.chop_lvl;   // chop level of this conversion
      end
   end

   // strobe one clock after store, word is already in place then
   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         sample_valid_o <= 1'b0;
      end else begin
         sample_valid_o <= ctrl.store;
      end
   end

endmodule : sdo_shifter

`default_nettype wire

//--- source/acq_top.sv
// ****************************
// all inputs synchronous to adc_read_clk, no back-pressure on sample words
// ****************************
`default_nettype none

module acq_top #(
   parameter int ADC_CHANNELS = 4      // even, two lanes per ADC
) (
   input  wire logic                                            adc_read_clk,
   input  wire logic                                            acqe_arst_sync,
   input  wire logic                                            strg_i,
   input  wire logic                                            chop_en_i,
   input  wire logic [acq_pkg::CHOP_WIDTH-1:0]                  max_count_i,
   input  wire logic [acq_pkg::CHOP_WIDTH-1:0]                  change_count_i,
   input  wire logic [ADC_CHANNELS-1:0]                         sdo_i,
   output      logic                                            cnvst_o,
   output      logic                                            sck_o,
   output      logic                                            chop_o,
   output      logic                                            acq_on_o,
   output      logic [ADC_CHANNELS*acq_pkg::ADC_DATA_WIDTH-1:0] sample_data_o,
   output      logic                                            sample_chop_o,
   output      logic                                            sample_valid_o
);

   import acq_pkg::*;

   logic [CNT_WIDTH-1:0] cycle_cnt;   // timer -> sequencer

   conv_ctrl_if ctrl_if ();

   // ****************************
   // timing
   // ****************************
   cycle_timer u_cycle_timer (
      .adc_read_clk   (adc_read_clk),
      .acqe_arst_sync (acqe_arst_sync),
      .count_o        (cycle_cnt)
   );

   conv_seq_fsm u_conv_seq_fsm (
      .adc_read_clk   (adc_read_clk),
      .acqe_arst_sync (acqe_arst_sync),
      .count_i        (cycle_cnt),
      .strg_i         (strg_i),
      .acq_on_o       (acq_on_o),
      .ctrl           (ctrl_if.seq)
   );

   chop_gen u_chop_gen (
      .adc_read_clk   (adc_read_clk),
      .acqe_arst_sync (acqe_arst_sync),
      .chop_en_i      (chop_en_i),
      .max_count_i    (max_count_i),
      .change_count_i (change_count_i),
      .ctrl           (ctrl_if.chop)
   );

   // ****************************
   // data path
   // ****************************
   sdo_shifter #(
      .ADC_CHANNELS (ADC_CHANNELS)
   ) u_sdo_shifter (
      .adc_read_clk   (adc_read_clk),
      .acqe_arst_sync (acqe_arst_sync),
      .sdo_i          (sdo_i),
      .ctrl           (ctrl_if.data),
      .sample_data_o  (sample_data_o),
      .sample_chop_o  (sample_chop_o),
      .sample_valid_o (sample_valid_o)
   );

   // ADC side pins
   assign cnvst_o = ctrl_if.cnvst;
   assign sck_o   = ctrl_if.sck;
   assign chop_o  = ctrl_if.chop_lvl;

endmodule : acq_top

`default_nettype wire

//--- bench/tb_clock_gen.sv
// ****************************
// free running clock, active low reset released shortly after a rising edge
// ****************************
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD     = 20,   // time units
   parameter int RST_CYCLES = 3
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;                  // asserted from time 0
      repeat (RST_CYCLES) @(posedge clk_o);
      #2 rst_n_o = 1'b1;
   end

endmodule : tb_clock_gen

`default_nettype wire

//--- bench/acq_assert.sv
// ****************************
// bound into conv_seq_fsm; the short first cycle after reset is skipped
// ****************************
`default_nettype none

module acq_assert (
   input wire logic                          adc_read_clk,
   input wire logic                          acqe_arst_sync,
   input wire logic [acq_pkg::CNT_WIDTH-1:0] count_i,
   input wire logic                          cnvst_i,
   input wire logic                          sck_i
);

   import acq_pkg::*;

   localparam logic [CNT_WIDTH-1:0] LAST_CNT = CNT_WIDTH'(CYCLE_LEN - 1);

   logic               warm_q;        // set once the first full cycle begins
   logic               sck_prev_q;    // sck one clock back
   logic [CNT_WIDTH:0] cnvst_cnt_q;   // cnvst high clocks so far this cycle
   logic [CNT_WIDTH:0] sck_cnt_q;     // sck pulses so far this cycle
   logic               sck_rise;

   assign sck_rise = sck_i && !sck_prev_q;   // start of one pulse

   // ****************************
   // per cycle tallies
   // ****************************
   always_ff @(posedge adc_read_clk or negedge acqe_arst_sync) begin
      if (!acqe_arst_sync) begin
         warm_q      <= 1'b0;
         sck_prev_q  <= 1'b0;
         cnvst_cnt_q <= '0;
         sck_cnt_q   <= '0;
      end else begin
         sck_prev_q <= sck_i;
         if (count_i == LAST_CNT) begin
            warm_q      <= 1'b1;
            cnvst_cnt_q <= '0;              // next cycle starts empty
            sck_cnt_q   <= '0;
         end else begin
            cnvst_cnt_q <= cnvst_cnt_q + (CNT_WIDTH + 1)'(cnvst_i);
            sck_cnt_q   <= sck_cnt_q + (CNT_WIDTH + 1)'(sck_rise);
         end
      end
   end

   // ****************************
   // strobe shape per cycle
   // ****************************
   // totals judged on the last count, its own level included
   cnvst_len_a : assert property (@(posedge adc_read_clk) disable iff (!acqe_arst_sync || !warm_q)
      (count_i == LAST_CNT) |-> (int'(cnvst_cnt_q) + int'(cnvst_i) == CNVST_LEN))
      else $error("cnvst_o not high for CNVST_LEN clocks in one cycle");

   sck_burst_a : assert property (@(posedge adc_read_clk) disable iff (!acqe_arst_sync || !warm_q)
      (count_i == LAST_CNT) |-> (int'(sck_cnt_q) + int'(sck_rise) == ADC_DATA_WIDTH))
      else $error("sck_o did not give ADC_DATA_WIDTH pulses in one cycle");

   no_overlap_a : assert property (@(posedge adc_read_clk) disable iff (!acqe_arst_sync)
      !(cnvst_i && sck_i)) else $error("cnvst_o and sck_o overlap");

endmodule : acq_assert

bind conv_seq_fsm acq_assert u_acq_assert (
   .adc_read_clk   (adc_read_clk),
   .acqe_arst_sync (acqe_arst_sync),
   .count_i        (count_i),
   .cnvst_i        (cnvst_q),
   .sck_i          (sck_q)
);

`default_nettype wire

//--- bench/acq_tb.sv
// ****************************
// drives trigger, chop setup and an ADC serial model; checks every sample word
// ****************************
`default_nettype none

module acq_tb;

   import acq_pkg::*;

   localparam int CH       = 4;
   localparam int N_SAMPLE = 40;                              // conversions checked
   localparam int TIMEOUT  = (N_SAMPLE + 8) * CYCLE_LEN * 20 + 2000;

   logic                         clk;
   logic                         rst_n;
   logic                         strg;
   logic                         chop_en;
   logic [CHOP_WIDTH-1:0]        max_cnt;
   logic [CHOP_WIDTH-1:0]        change_cnt;
   logic [CH-1:0]                sdo;
   logic                         cnvst;
   logic                         sck;
   logic                         chop;
   logic                         acq_on;
   logic                         s_chop;
   logic                         s_valid;
   logic [CH*ADC_DATA_WIDTH-1:0] s_data;

   logic [ADC_DATA_WIDTH-1:0] cur_vals [CH];   // model's draw for this conversion
   int   bit_k;                                 // sck pulse index
   logic neg_cnvst;
   logic neg_sck;
   logic prev_cnvst;
   int   ref_period;
   logic ref_chop;
   int   n_samples;
   int   since_valid;
   int   err_cnt;
   logic triggered;
   logic run_seen;                              // cycle start seen after trigger

   tb_clock_gen #(.PERIOD(20), .RST_CYCLES(3)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

   acq_top #(.ADC_CHANNELS(CH)) uut (
      .adc_read_clk(clk), .acqe_arst_sync(rst_n), .strg_i(strg), .chop_en_i(chop_en),
      .max_count_i(max_cnt), .change_count_i(change_cnt), .sdo_i(sdo),
      .cnvst_o(cnvst), .sck_o(sck), .chop_o(chop), .acq_on_o(acq_on),
      .sample_data_o(s_data), .sample_chop_o(s_chop), .sample_valid_o(s_valid)
   );

   // ****************************
   // reference model
   // ****************************
   function automatic int next_period(input int period, input int maxc);
      return (period + 1 >= maxc) ? 0 : period + 1;   // wrap after max - 1
   endfunction

   function automatic logic [CH*ADC_DATA_WIDTH-1:0] expected_word();
      logic [CH*ADC_DATA_WIDTH-1:0] w;
      w = '0;
      for (int c = 0; c < CH; c++) w[c*ADC_DATA_WIDTH +: ADC_DATA_WIDTH] = cur_vals[c];
      return w;                                        // channel 0 low
   endfunction

   task automatic stop_failed();
      err_cnt++;
      $display("Some tests failed");
      $fatal(1, "run stopped at first error");
   endtask

   // levels just before each rising edge
   always @(negedge clk) begin
      neg_cnvst <= cnvst;
      neg_sck   <= sck;
   end

   // ADC serial model, lanes move only after an sck high clock
   always @(posedge clk) begin
      #1;
      if (rst_n && neg_cnvst && !prev_cnvst) begin
         for (int c = 0; c < CH; c++) begin
            cur_vals[c] = ADC_DATA_WIDTH'($urandom);
            sdo[c]      = cur_vals[c][ADC_DATA_WIDTH-1];
         end
         bit_k = 0;
         // first cycle start after the trigger moves the FSM to RUN
         if (triggered) begin
            run_seen = 1'b1;
         end
         // chop level for this conversion
         if (!chop_en) begin
            ref_period = 0;
            ref_chop   = 1'b0;
         end else begin
            ref_period = next_period(ref_period, int'(max_cnt));
            ref_chop   = (ref_period < int'(change_cnt));
         end
      end else if (neg_sck && bit_k < ADC_DATA_WIDTH - 1) begin
         bit_k = bit_k + 1;
         for (int c = 0; c < CH; c++) sdo[c] = cur_vals[c][ADC_DATA_WIDTH-1-bit_k];
      end
      prev_cnvst = neg_cnvst;
   end

   // ****************************
   // comparing process
   // ****************************
   always @(negedge clk) begin
      if (rst_n) begin
         since_valid = since_valid + 1;
         if (triggered) assert (acq_on) else begin
            $display("acq_on_o dropped after the trigger at %0t", $time);
            stop_failed();
         end
         if (s_valid) begin
            assert (run_seen) else begin
               $display("sample_valid_o seen before RUN was reached at %0t", $time);
               stop_failed();
            end
            if (n_samples > 0) assert (since_valid == CYCLE_LEN) else begin
               $display("FAILED t=%0t sample_valid_o spacing got %0d exp %0d", $time,
                        since_valid, CYCLE_LEN);
               stop_failed();
            end
            assert (s_data == expected_word()) else begin
               $display("FAILED t=%0t sample_data_o got %h exp %h", $time, s_data,
                        expected_word());
               stop_failed();
            end
            assert (s_chop == ref_chop) else begin
               $display("FAILED t=%0t sample_chop_o got %b exp %b", $time, s_chop, ref_chop);
               stop_failed();
            end
            // chopper pin still holds this conversion's level
            assert (chop == ref_chop) else begin
               $display("FAILED t=%0t chop_o got %b exp %b", $time, chop, ref_chop);
               stop_failed();
            end
            since_valid = 0;
            n_samples   = n_samples + 1;
         end
      end
   end

   // ****************************
   // stimulus
   // ****************************
   initial begin
      void'($urandom(32'he237_b22b));
      strg        = 1'b1;                 // held through reset, no edge
      chop_en     = 1'b0;
      max_cnt     = '0;
      change_cnt  = '0;
      sdo         = '0;
      prev_cnvst  = 1'b0;
      bit_k       = 0;
      ref_period  = 0;
      ref_chop    = 1'b0;
      n_samples   = 0;
      since_valid = 0;
      err_cnt     = 0;
      triggered   = 1'b0;
      run_seen    = 1'b0;
      for (int c = 0; c < CH; c++) cur_vals[c] = '0;
      @(posedge rst_n);
      // longer than one cycle, a store point passes before the trigger
      repeat (80) @(posedge clk);
      #1;
      assert (!acq_on) else begin
         $display("acq_on_o raised by a level held through reset");
         stop_failed();
      end
      #1 strg = 1'b0;
      repeat (4) @(posedge clk);
      #2 strg = 1'b1;
      @(posedge clk);                     // first clock that samples it high
      #1;
      assert (!acq_on) else begin
         $display("acq_on_o raised one clock early");
         stop_failed();
      end
      @(posedge clk);
      #1;
      assert (acq_on) else begin
         $display("acq_on_o not raised two clocks after the trigger");
         stop_failed();
      end
      triggered = 1'b1;
      // phase 2 and 3, random chop settings changed right after a sample
      for (int ph = 1; ph <= 3; ph++) begin
         wait (n_samples >= ph * 10);
         @(posedge clk);
         #2;
         chop_en    = (ph != 3) || ($urandom % 2 == 0);
         max_cnt    = CHOP_WIDTH'(1 + $urandom % 8);
         change_cnt = CHOP_WIDTH'($urandom % (int'(max_cnt) + 1));
      end
      wait (n_samples >= N_SAMPLE);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT);
      $display("timeout, not enough sample words arrived");
      $display("Some tests failed");
      $fatal(1, "watchdog expired");
   end

endmodule : acq_tb

`default_nettype wire

//--- flist.f
source/acq_pkg.sv
source/conv_ctrl_if.sv
source/cycle_timer.sv
source/conv_seq_fsm.sv
source/chop_gen.sv
source/sdo_shifter.sv
source/acq_top.sv
bench/tb_clock_gen.sv
bench/acq_assert.sv
bench/acq_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= acq_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f flist.f --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
